// File: logic/lsu_defs.svh
// ------------------------------------------------
// global widths and sizes of the load/store unit
// memory depth, request buffer depth and the
// exception cause codes
// ------------------------------------------------
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data and address width
`define LSU_XLEN                64
// byte lanes per memory word
`define LSU_NUM_BYTES           8

// local data memory, 32 doublewords
`define LSU_MEM_WORDS           32
`define LSU_WORD_IDX_W          5

// request buffer entries
`define LSU_BUF_DEPTH           2

// transaction id width
`define LSU_TID_W               3

// exception causes, RISC-V mcause encoding
`define LSU_CAUSE_LD_MISALIGNED 4'd4
`define LSU_CAUSE_ST_MISALIGNED 4'd6

`endif

// File: logic/lsu_pkg.sv
// ------------------------------------------------
// load/store unit types
// operation enum, request, control and response
// structs, memory word union
// ------------------------------------------------
`include "lsu_defs.svh"

package lsu_pkg;

    // ------------------------------------------------
    // operations
    // ------------------------------------------------
    typedef enum logic [3:0] {
        LB  = 4'd0,
        LBU = 4'd1,
        LH  = 4'd2,
        LHU = 4'd3,
        LW  = 4'd4,
        LWU = 4'd5,
        LD  = 4'd6,
        SB  = 4'd7,
        SH  = 4'd8,
        SW  = 4'd9,
        SD  = 4'd10
    } lsu_op_e;

    // memory port fields
    typedef logic [`LSU_WORD_IDX_W-1:0] word_idx_t;
    typedef logic [`LSU_NUM_BYTES-1:0]  be_t;

    // ------------------------------------------------
    // request, control and response
    // ------------------------------------------------
    // issue side request, imm arrives sign-extended
    typedef struct packed {
        lsu_op_e               op;
        logic [`LSU_XLEN-1:0]  base;
        logic [`LSU_XLEN-1:0]  imm;
        logic [`LSU_XLEN-1:0]  wdata;
        logic [`LSU_TID_W-1:0] trans_id;
    } lsu_req_t;

    // request after address generation
    typedef struct packed {
        lsu_op_e               op;
        logic [`LSU_XLEN-1:0]  vaddr;
        logic [`LSU_XLEN-1:0]  wdata;
        be_t                   be;
        logic [`LSU_TID_W-1:0] trans_id;
        logic                  misaligned;
    } lsu_ctrl_t;

    // write-back response
    // result holds load data or the faulting address
    typedef struct packed {
        logic [`LSU_TID_W-1:0] trans_id;
        logic                  is_store;
        logic                  exc_valid;
        logic [3:0]            cause;
        logic [`LSU_XLEN-1:0]  result;
    } lsu_resp_t;

    // one memory word, whole or per byte lane
    typedef union packed {
        logic [`LSU_XLEN-1:0]               dword;
        logic [`LSU_NUM_BYTES-1:0][7:0]     lane;
    } mem_word_u;

endpackage

// File: logic/lsu_agu.sv
// ------------------------------------------------
// address generation unit
// virtual address, access size, byte enables and
// misalignment detection
// ------------------------------------------------
`timescale 1ns/1ps

module lsu_agu import lsu_pkg::*; (
    input  lsu_req_t  req_i,
    output lsu_ctrl_t ctrl_o
);

    // access size codes
    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;
    localparam logic [1:0] SIZE_D = 2'd3;

    logic [$bits(req_i.base)-1:0] vaddr;
    logic [2:0]                   off;
    logic [1:0]                   size;
    be_t                          be;
    logic                         misaligned;

    // base plus sign-extended immediate, wraps at xlen
    assign vaddr = req_i.base + req_i.imm;
    assign off   = vaddr[2:0];

    // operation to access size
    always_comb begin
        case (req_i.op)
            LB, LBU, SB: size = SIZE_B;
            LH, LHU, SH: size = SIZE_H;
            LW, LWU, SW: size = SIZE_W;
            default:     size = SIZE_D;
        endcase
    end

    // byte enables from offset and size
    // misaligned case leaves garbage here, never used
    always_comb begin
        case (size)
            SIZE_B:  be = be_t'(8'h01) << off;
            SIZE_H:  be = be_t'(8'h03) << off;
            SIZE_W:  be = be_t'(8'h0f) << off;
            default: be = be_t'(8'hff);
        endcase
    end

    // low bits must be zero for the access size
    // byte accesses always aligned
    always_comb begin
        case (size)
            SIZE_H:  misaligned = off[0];
            SIZE_W:  misaligned = |off[1:0];
            SIZE_D:  misaligned = |off;
            default: misaligned = 1'b0;
        endcase
    end

    always_comb begin
        ctrl_o            = '0;
        ctrl_o.op         = req_i.op;
        ctrl_o.vaddr      = vaddr;
        ctrl_o.wdata      = req_i.wdata;
        ctrl_o.be         = be;
        ctrl_o.trans_id   = req_i.trans_id;
        ctrl_o.misaligned = misaligned;
    end

endmodule

// File: logic/lsu_req_buffer.sv
// ------------------------------------------------
// request buffer between issue and execute
// small circular FIFO, bypass when empty
// ------------------------------------------------
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_req_buffer import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      in_valid_i,
    input  lsu_ctrl_t in_ctrl_i,
    output logic      in_ready_o,
    output logic      head_valid_o,
    output lsu_ctrl_t head_o,
    input  logic      pop_i
);

    localparam int unsigned DEPTH = `LSU_BUF_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    lsu_ctrl_t        mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             empty;
    logic             push;

    assign empty      = (count_q == '0);
    assign in_ready_o = (count_q < CNT_W'(DEPTH));
    assign push       = in_valid_i && in_ready_o;

    // empty: incoming entry straight to the head
    assign head_valid_o = empty ? in_valid_i : 1'b1;
    assign head_o       = empty ? in_ctrl_i : mem_q[rd_ptr_q];

    // pointers and occupancy
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            // bypassed entry also advances the read side
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // push and pop together hold the count
            if (push && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (!push && pop_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_ctrl_i;
        end
    end

endmodule

// File: logic/lsu_exec.sv
// ------------------------------------------------
// in-order execute controller
// memory issue, load lane extraction and
// extension, response register
// ------------------------------------------------
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_exec import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      head_valid_i,
    input  lsu_ctrl_t head_i,
    output logic      pop_o,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output word_idx_t mem_idx_o,
    output mem_word_u mem_wdata_o,
    output be_t       mem_be_o,
    input  mem_word_u mem_rdata_i,
    output logic      resp_valid_o,
    output lsu_resp_t resp_o,
    input  logic      resp_ready_i
);

    // load waiting for its read data
    typedef struct packed {
        lsu_op_e               op;
        logic [2:0]            off;
        logic [`LSU_TID_W-1:0] trans_id;
    } ld_info_t;

    logic                 head_store;
    logic                 resp_free;
    logic                 issue;
    logic                 issue_resp;
    logic                 ld_pend_q;
    ld_info_t             ld_info_q;
    logic                 resp_valid_q;
    lsu_resp_t            resp_q;
    lsu_resp_t            head_resp;
    lsu_resp_t            ld_resp;
    logic [`LSU_XLEN-1:0] ld_shift;
    logic [7:0]           ld_byte;
    logic [`LSU_XLEN-1:0] ld_result;

    // ------------------------------------------------
    // issue
    // ------------------------------------------------
    assign head_store = head_i.op inside {SB, SH, SW, SD};
    assign resp_free  = !resp_valid_q || resp_ready_i;
    // no issue while a load is in its data cycle
    assign issue      = head_valid_i && !ld_pend_q && resp_free;
    assign pop_o      = issue;
    // stores and misaligned ops respond right at issue
    assign issue_resp = issue && (head_store || head_i.misaligned);

    // misaligned never reaches memory
    assign mem_req_o = issue && !head_i.misaligned;
    assign mem_we_o  = head_store;
    assign mem_idx_o = head_i.vaddr[`LSU_WORD_IDX_W+2:3];
    assign mem_be_o  = head_i.be;

    // store data moved up to the addressed lanes
    always_comb begin
        mem_wdata_o.dword = head_i.wdata << {head_i.vaddr[2:0], 3'b000};
    end

    // store ack or misalignment exception
    always_comb begin
        head_resp           = '0;
        head_resp.trans_id  = head_i.trans_id;
        head_resp.is_store  = head_store;
        head_resp.exc_valid = head_i.misaligned;
        if (head_i.misaligned) begin
            head_resp.cause  = head_store ? `LSU_CAUSE_ST_MISALIGNED
                                          : `LSU_CAUSE_LD_MISALIGNED;
            // faulting address reported in the result
            head_resp.result = head_i.vaddr;
        end
    end

    // ------------------------------------------------
    // load data cycle
    // ------------------------------------------------
    assign ld_shift = mem_rdata_i.dword >> {ld_info_q.off, 3'b000};
    assign ld_byte  = mem_rdata_i.lane[ld_info_q.off];

    // sign or zero extension by operation
    always_comb begin
        case (ld_info_q.op)
            LB:      ld_result = {{(`LSU_XLEN-8){ld_byte[7]}}, ld_byte};
            LBU:     ld_result = {{(`LSU_XLEN-8){1'b0}}, ld_byte};
            LH:      ld_result = {{(`LSU_XLEN-16){ld_shift[15]}}, ld_shift[15:0]};
            LHU:     ld_result = {{(`LSU_XLEN-16){1'b0}}, ld_shift[15:0]};
            LW:      ld_result = {{(`LSU_XLEN-32){ld_shift[31]}}, ld_shift[31:0]};
            LWU:     ld_result = {{(`LSU_XLEN-32){1'b0}}, ld_shift[31:0]};
            default: ld_result = mem_rdata_i.dword;
        endcase
    end

    always_comb begin
        ld_resp          = '0;
        ld_resp.trans_id = ld_info_q.trans_id;
        ld_resp.result   = ld_result;
    end

    // ------------------------------------------------
    // state
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ld_pend_q    <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            ld_pend_q <= issue && !head_store && !head_i.misaligned;
            // response register is free whenever a load finishes
            if (ld_pend_q || issue_resp) begin
                resp_valid_q <= 1'b1;
            end else if (resp_ready_i) begin
                resp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            ld_info_q.op       <= head_i.op;
            ld_info_q.off      <= head_i.vaddr[2:0];
            ld_info_q.trans_id <= head_i.trans_id;
        end
        if (ld_pend_q) begin
            resp_q <= ld_resp;
        end else if (issue_resp) begin
            resp_q <= head_resp;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign resp_o       = resp_q;

endmodule

// File: logic/lsu_sram.sv
// ------------------------------------------------
// single-port local data memory
// byte-enabled writes, one-cycle read latency
// ------------------------------------------------
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_sram import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      req_i,
    input  logic      we_i,
    input  word_idx_t idx_i,
    input  mem_word_u wdata_i,
    input  be_t       be_i,
    output mem_word_u rdata_o
);

    mem_word_u ram [`LSU_MEM_WORDS];
    word_idx_t raddr_q;

    // write port, lane by lane
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int i = 0; i < `LSU_NUM_BYTES; i++) begin
                if (be_i[i]) begin
                    ram[idx_i].lane[i] <= wdata_i.lane[i];
                end
            end
        end
    end

    // read address register
    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            raddr_q <= idx_i;
        end
    end

    // data valid the cycle after the read
    assign rdata_o = ram[raddr_q];

endmodule

// File: logic/lsu_top.sv
// ------------------------------------------------
// load/store unit top level
// address generation, request buffer, execute
// controller and local data memory
// ------------------------------------------------
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      req_valid_i,
    input  lsu_req_t  req_i,
    output logic      req_ready_o,
    output logic      resp_valid_o,
    output lsu_resp_t resp_o,
    input  logic      resp_ready_i
);

    // agu to buffer
    lsu_ctrl_t in_ctrl;

    // buffer head to execute
    logic      head_valid;
    lsu_ctrl_t head;
    logic      pop;

    // memory port
    logic      mem_req;
    logic      mem_we;
    word_idx_t mem_idx;
    mem_word_u mem_wdata;
    be_t       mem_be;
    mem_word_u mem_rdata;

    lsu_agu i_agu (
        .req_i  ( req_i   ),
        .ctrl_o ( in_ctrl )
    );

    lsu_req_buffer i_req_buffer (
        .clk_i        ( clk_i       ),
        .rst_ni       ( rst_ni      ),
        .in_valid_i   ( req_valid_i ),
        .in_ctrl_i    ( in_ctrl     ),
        .in_ready_o   ( req_ready_o ),
        .head_valid_o ( head_valid  ),
        .head_o       ( head        ),
        .pop_i        ( pop         )
    );

    lsu_exec i_exec (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .head_valid_i ( head_valid   ),
        .head_i       ( head         ),
        .pop_o        ( pop          ),
        .mem_req_o    ( mem_req      ),
        .mem_we_o     ( mem_we       ),
        .mem_idx_o    ( mem_idx      ),
        .mem_wdata_o  ( mem_wdata    ),
        .mem_be_o     ( mem_be       ),
        .mem_rdata_i  ( mem_rdata    ),
        .resp_valid_o ( resp_valid_o ),
        .resp_o       ( resp_o       ),
        .resp_ready_i ( resp_ready_i )
    );

    lsu_sram i_sram (
        .clk_i   ( clk_i     ),
        .req_i   ( mem_req   ),
        .we_i    ( mem_we    ),
        .idx_i   ( mem_idx   ),
        .wdata_i ( mem_wdata ),
        .be_i    ( mem_be    ),
        .rdata_o ( mem_rdata )
    );

endmodule

// File: test/lsu_tb_checks.svh
// -------------------------------------------------
// response compare tasks for the load/store unit
// id and store flag, exception, result
// -------------------------------------------------
`ifndef LSU_TB_CHECKS_SVH
`define LSU_TB_CHECKS_SVH

// transaction id and store flag
task automatic check_resp_id(input lsu_resp_t got, input lsu_resp_t expected);
    if (got.trans_id !== expected.trans_id || got.is_store !== expected.is_store) begin
        fail_run($sformatf("** Error at %0t: id/store got %0d/%0b, expected %0d/%0b",
                           $time, got.trans_id, got.is_store,
                           expected.trans_id, expected.is_store));
    end
endtask

// exception flag and cause code
task automatic check_exception(input lsu_resp_t got, input lsu_resp_t expected);
    if (got.exc_valid !== expected.exc_valid || got.cause !== expected.cause) begin
        fail_run($sformatf("** Error at %0t: id %0d exc/cause got %0b/%0d, expected %0b/%0d",
                           $time, expected.trans_id, got.exc_valid, got.cause,
                           expected.exc_valid, expected.cause));
    end
endtask

// load data, or faulting address on an exception
task automatic check_result(input lsu_resp_t got, input lsu_resp_t expected);
    if (got.result !== expected.result) begin
        fail_run($sformatf("** Error at %0t: id %0d result got %h, expected %h",
                           $time, expected.trans_id, got.result, expected.result));
    end
endtask

`endif

// File: test/lsu_tb.sv
// -------------------------------------------------
// testbench for the load/store unit
// clock and reset, test file reader, request driver,
// response monitor, back-pressure and timeout
// -------------------------------------------------
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int MAX_TESTS    = 64;
    localparam int CLK_HALF     = 20;
    localparam int CYC_PER_TEST = 40;
    localparam int CYC_MARGIN   = 200;

    // one line of the test file
    typedef struct packed {
        lsu_req_t  req;
        lsu_resp_t resp;
    } test_vec_t;

    logic      clk_i;
    logic      rst_ni;
    logic      req_valid_i;
    lsu_req_t  req_i;
    logic      req_ready_o;
    logic      resp_valid_o;
    lsu_resp_t resp_o;
    logic      resp_ready_i = 1'b0;

    test_vec_t tests [MAX_TESTS];
    int        n_tests     = 0;
    lsu_resp_t exp_q [$];
    int        got_count   = 0;
    int        cycle_count = 0;
    int        cycle_limit = 0;
    logic      draining    = 1'b0;
    int        stall_left  = 0;
    logic      held_valid  = 1'b0;
    lsu_resp_t held_resp;

    lsu_top UUT (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .req_valid_i  ( req_valid_i  ),
        .req_i        ( req_i        ),
        .req_ready_o  ( req_ready_o  ),
        .resp_valid_o ( resp_valid_o ),
        .resp_o       ( resp_o       ),
        .resp_ready_i ( resp_ready_i )
    );

    // report the reason and end the run
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    `include "lsu_tb_checks.svh"

    task automatic check_idle_state();
        if (resp_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
            fail_run($sformatf("** Error at %0t: reset state valid/ready %0b/%0b, expected 0/1",
                               $time, resp_valid_o, req_ready_o));
        end
    endtask

    // -------------------------------------------------
    // test file reader
    // -------------------------------------------------
    task automatic load_tests();
        int                    fd;
        int                    n;
        string                 line;
        logic [3:0]            op;
        logic [`LSU_XLEN-1:0]  base;
        logic [`LSU_XLEN-1:0]  imm;
        logic [`LSU_XLEN-1:0]  wdata;
        logic [`LSU_XLEN-1:0]  result;
        logic [`LSU_TID_W-1:0] tid;
        logic                  is_store;
        logic                  exc_valid;
        logic [3:0]            cause;
        fd = $fopen("test/lsu_tests.txt", "r");
        if (fd == 0) begin
            fail_run("could not open test/lsu_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip blank and comment lines
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", op, base, imm, wdata,
                            tid, is_store, exc_valid, cause, result);
                if (n != 9 || op > SD || n_tests >= MAX_TESTS) begin
                    fail_run($sformatf("bad line in test file: %s", line));
                end
                tests[n_tests]                = '0;
                tests[n_tests].req.op         = lsu_op_e'(op);
                tests[n_tests].req.base       = base;
                tests[n_tests].req.imm        = imm;
                tests[n_tests].req.wdata      = wdata;
                tests[n_tests].req.trans_id   = tid;
                tests[n_tests].resp.trans_id  = tid;
                tests[n_tests].resp.is_store  = is_store;
                tests[n_tests].resp.exc_valid = exc_valid;
                tests[n_tests].resp.cause     = cause;
                tests[n_tests].resp.result    = result;
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    // -------------------------------------------------
    // request driver with random idle gaps
    // -------------------------------------------------
    task automatic drive_requests();
        int gap;
        for (int i = 0; i < n_tests; i++) begin
            gap = (($urandom % 3) == 0) ? int'($urandom % 4) + 1 : 0;
            if (gap > 0) begin
                req_valid_i <= 1'b0;
                repeat (gap) @(posedge clk_i);
            end
            req_valid_i <= 1'b1;
            req_i       <= tests[i].req;
            @(posedge clk_i);
            // request held until ready
            while (!req_ready_o) begin
                @(posedge clk_i);
            end
            exp_q.push_back(tests[i].resp);
        end
        req_valid_i <= 1'b0;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_HALF) clk_i = ~clk_i;
    end

    // random back-pressure with occasional long stalls
    always @(posedge clk_i) begin
        if (draining) begin
            resp_ready_i <= 1'b1;
        end else if (stall_left > 0) begin
            resp_ready_i <= 1'b0;
            stall_left   <= stall_left - 1;
        end else if (($urandom % 12) == 0) begin
            // long enough to fill the request buffer
            resp_ready_i <= 1'b0;
            stall_left   <= 4 + int'($urandom % 4);
        end else begin
            resp_ready_i <= ($urandom % 3) != 0;
        end
    end

    // -------------------------------------------------
    // response monitor
    // -------------------------------------------------
    always @(posedge clk_i) begin : resp_monitor
        lsu_resp_t expected;
        if (rst_ni) begin
            // a stalled response stays put
            if (held_valid && (!resp_valid_o || resp_o !== held_resp)) begin
                fail_run($sformatf("** Error at %0t: response changed while stalled", $time));
            end
            held_valid <= resp_valid_o && !resp_ready_i;
            held_resp  <= resp_o;
            if (resp_valid_o && resp_ready_i) begin
                if (exp_q.size() == 0) begin
                    fail_run("a response arrived with no request outstanding");
                end
                expected = exp_q.pop_front();
                check_resp_id(resp_o, expected);
                check_exception(resp_o, expected);
                check_result(resp_o, expected);
                got_count++;
            end
        end
    end

    // run limit from the number of test lines
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles, responses stopped (%0d of %0d)",
                               cycle_count, got_count, n_tests));
        end
    end

    initial begin
        void'($urandom(33));
        rst_ni      = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        load_tests();
        cycle_limit = n_tests * CYC_PER_TEST + CYC_MARGIN;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        // first cycle out of reset, no request yet
        @(posedge clk_i);
        check_idle_state();
        drive_requests();
        while (got_count < n_tests) begin
            @(posedge clk_i);
        end
        // nothing more may come out
        draining = 1'b1;
        repeat (10) @(posedge clk_i);
        if (got_count == n_tests && exp_q.size() == 0 && !resp_valid_o) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_run("extra responses after the last request");
        end
    end

endmodule

// File: test/lsu_tests.txt
# op base imm wdata tid, then expected is_store exc_valid cause result, all hex
# op: 0 lb, 1 lbu, 2 lh, 3 lhu, 4 lw, 5 lwu, 6 ld, 7 sb, 8 sh, 9 sw, a sd
# doubleword round trip, word 2
a 1000 10 0123456789abcdef 0 1 0 0 0
6 1000 10 0 1 0 0 0 0123456789abcdef
# byte lanes merged into word 4, then extension
a 20 0 1111111111111111 2 1 0 0 0
7 20 1 deadbeefcafe0080 3 1 0 0 0
8 20 2 123456789abcfedc 4 1 0 0 0
9 20 4 5555555589abcdef 5 1 0 0 0
0 20 1 0 6 0 0 0 ffffffffffffff80
1 20 1 0 7 0 0 0 80
2 20 2 0 1 0 0 0 fffffffffffffedc
3 20 2 0 2 0 0 0 fedc
4 20 4 0 3 0 0 0 ffffffff89abcdef
5 20 4 0 4 0 0 0 89abcdef
2 20 6 0 6 0 0 0 ffffffffffff89ab
6 20 0 0 7 0 0 0 89abcdeffedc8011
# misaligned accesses on word 6 leave memory alone
a 30 0 0f0e0d0c0b0a0908 0 1 0 0 0
2 30 1 0 1 0 1 4 31
4 30 2 0 2 0 1 4 32
a 30 4 ffffffffffffffff 3 1 1 6 34
8 30 3 ffff 4 1 1 6 33
6 30 0 0 5 0 0 0 0f0e0d0c0b0a0908
# negative immediate and high address bits, word 9
a 40 8 a5a5a5a5a5a5a5a5 6 1 0 0 0
6 58 fffffffffffffff0 0 7 0 0 0 a5a5a5a5a5a5a5a5
7 100 49 77 0 1 0 0 0
6 ffffffff00000400 48 0 1 0 0 0 a5a5a5a5a5a577a5
4 7000000000000000 4a 0 2 0 1 4 700000000000004a
# store then load to the same word, word 10
a 50 0 1 3 1 0 0 0
6 50 0 0 4 0 0 0 1
a 50 0 2 5 1 0 0 0
6 50 0 0 6 0 0 0 2
9 50 4 ffffffff 7 1 0 0 0
6 50 0 0 0 0 0 0 ffffffff00000002
1 50 7 0 1 0 0 0 ff
2 48 0 0 3 0 0 0 77a5

// File: vlog.f
+incdir+logic
+incdir+test
logic/lsu_pkg.sv
logic/lsu_agu.sv
logic/lsu_req_buffer.sv
logic/lsu_exec.sv
logic/lsu_sram.sv
logic/lsu_top.sv
test/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the load/store unit testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module lsu_tb \
    -Mdir obj_dir -o lsu_sim

# pass or fail comes from the log
./obj_dir/lsu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
